// ==== design/rv_core_cfg.svh ====
// Core and memory configuration shared by the design files
// RV_MEM_RD_LAT must be at least 1; registers sit in the first 32 words

`ifndef RV_CORE_CFG_SVH
`define RV_CORE_CFG_SVH

// Data path width
`define RV_XLEN 32

// Byte address width
`define RV_AW 16

// Memory depth in words
`define RV_MEM_WORDS 1024

// First instruction sits above x0..x31 at 0x00..0x7C
`define RV_RESET_PC 16'h0080

// Cycles from rd_en rising to the rd_valid pulse
`define RV_MEM_RD_LAT 2

`endif

// ==== design/rv_core_pkg.sv ====
// Types shared by the RV32I subset core, its memory and the testbench
// Instruction fields follow the base RV32I encodings

`default_nettype none

`include "rv_core_cfg.svh"

package rv_core_pkg;

   typedef enum logic [6:0] {
      OP_R_ALU  = 7'b0110011,
      OP_I_ALU  = 7'b0010011,
      OP_LOAD   = 7'b0000011,
      OP_STORE  = 7'b0100011,
      OP_BRANCH = 7'b1100011,
      OP_JAL    = 7'b1101111,
      OP_JALR   = 7'b1100111,
      OP_LUI    = 7'b0110111,
      OP_SYSTEM = 7'b1110011   // Only ebreak
   } opcode_e;

   // {funct7[5], funct3}
   typedef enum logic [3:0] {
      ALU_ADD = 4'h0,
      ALU_SLL = 4'h1,
      ALU_SLT = 4'h2,
      ALU_XOR = 4'h4,
      ALU_SRL = 4'h5,
      ALU_OR  = 4'h6,
      ALU_AND = 4'h7,
      ALU_SUB = 4'h8
   } alu_fn_e;

   typedef struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
   } r_fmt_s;

   typedef struct packed {
      logic [11:0] imm;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
   } i_fmt_s;

   typedef struct packed {
      logic [6:0] imm_hi;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] imm_lo;
      logic [6:0] opcode;
   } s_fmt_s;

   typedef struct packed {
      logic       imm_12;
      logic [5:0] imm_10_5;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [3:0] imm_4_1;
      logic       imm_11;
      logic [6:0] opcode;
   } b_fmt_s;

   typedef struct packed {
      logic [19:0] imm;
      logic [4:0]  rd;
      logic [6:0]  opcode;
   } u_fmt_s;

   typedef struct packed {
      logic       imm_20;
      logic [9:0] imm_10_1;
      logic       imm_11;
      logic [7:0] imm_19_12;
      logic [4:0] rd;
      logic [6:0] opcode;
   } j_fmt_s;

   typedef union packed {
      r_fmt_s r_fmt;
      i_fmt_s i_fmt;
      s_fmt_s s_fmt;
      b_fmt_s b_fmt;
      u_fmt_s u_fmt;
      j_fmt_s j_fmt;
   } inst_u;

   typedef struct packed {
      opcode_e              opcode;
      logic [4:0]           rd;
      logic [4:0]           rs1;
      logic [4:0]           rs2;
      logic [2:0]           funct3;
      alu_fn_e              alu_fn;
      logic [`RV_XLEN-1:0]  imm;
      logic                 need_rs1;
      logic                 need_rs2;
      logic                 use_rs2;   // ALU b from rs2, else imm
      logic                 illegal;
   } dec_s;

   typedef struct packed {
      logic                 rd_en;
      logic                 wr_en;
      logic [`RV_AW-1:0]    addr;    // Byte address
      logic [`RV_XLEN-1:0]  wdata;
   } mem_req_s;

   typedef struct packed {
      logic                 valid;
      logic                 write;
      logic [`RV_AW-1:0]    addr;
      logic [`RV_XLEN-1:0]  data;
   } host_req_s;

endpackage

`default_nettype wire

// ==== design/rv_alu.sv ====
// Combinational ALU; slt compares unsigned and shifts use b[4:0]
// Unknown function codes give zero

`timescale 1ns/10ps
`default_nettype none

`include "rv_core_cfg.svh"

module rv_alu (
   input  wire [`RV_XLEN-1:0]       i_a,
   input  wire [`RV_XLEN-1:0]       i_b,
   input  wire rv_core_pkg::alu_fn_e i_fn,
   output logic [`RV_XLEN-1:0]      o_out,
   output logic                     o_zero
);

   always_comb begin
      case (i_fn)
         rv_core_pkg::ALU_ADD: o_out = i_a + i_b;
         rv_core_pkg::ALU_SUB: o_out = i_a - i_b;
         rv_core_pkg::ALU_XOR: o_out = i_a ^ i_b;
         rv_core_pkg::ALU_OR:  o_out = i_a | i_b;
         rv_core_pkg::ALU_AND: o_out = i_a & i_b;
         rv_core_pkg::ALU_SLL: o_out = i_a << i_b[4:0];
         rv_core_pkg::ALU_SRL: o_out = i_a >> i_b[4:0];
         rv_core_pkg::ALU_SLT: o_out = (i_a < i_b) ? `RV_XLEN'd1 : `RV_XLEN'd0;
         default:              o_out = '0;
      endcase
   end

   // beq/bne look at this after a subtract
   assign o_zero = (o_out == '0);

endmodule

`default_nettype wire

// ==== design/rv_decoder.sv ====
// Splits one instruction word into fields, operand needs and immediate
// Only the opcodes of the supported RV32I subset are legal

`timescale 1ns/10ps
`default_nettype none

`include "rv_core_cfg.svh"

module rv_decoder (
   input  wire rv_core_pkg::inst_u i_inst,
   output rv_core_pkg::dec_s       o_dec
);

   always_comb begin
      o_dec          = '0;
      o_dec.opcode   = rv_core_pkg::opcode_e'(i_inst.r_fmt.opcode);
      o_dec.rd       = i_inst.r_fmt.rd;
      o_dec.rs1      = i_inst.r_fmt.rs1;
      o_dec.rs2      = i_inst.r_fmt.rs2;
      o_dec.funct3   = i_inst.r_fmt.funct3;
      o_dec.alu_fn   = rv_core_pkg::ALU_ADD;   // Loads, stores, jalr

      case (i_inst.r_fmt.opcode)
         rv_core_pkg::OP_R_ALU: begin
            o_dec.alu_fn   = rv_core_pkg::alu_fn_e'({i_inst.r_fmt.funct7[5],
                                                     i_inst.r_fmt.funct3});
            o_dec.need_rs1 = 1'b1;
            o_dec.need_rs2 = 1'b1;
            o_dec.use_rs2  = 1'b1;
         end
         rv_core_pkg::OP_I_ALU: begin
            // imm[10] is not a funct7 bit here
            o_dec.alu_fn   = rv_core_pkg::alu_fn_e'({1'b0, i_inst.i_fmt.funct3});
            o_dec.imm      = {{20{i_inst.i_fmt.imm[11]}}, i_inst.i_fmt.imm};
            o_dec.need_rs1 = 1'b1;
         end
         rv_core_pkg::OP_LOAD,
         rv_core_pkg::OP_JALR: begin
            o_dec.imm      = {{20{i_inst.i_fmt.imm[11]}}, i_inst.i_fmt.imm};
            o_dec.need_rs1 = 1'b1;
         end
         rv_core_pkg::OP_STORE: begin
            o_dec.imm      = {{20{i_inst.s_fmt.imm_hi[6]}}, i_inst.s_fmt.imm_hi,
                              i_inst.s_fmt.imm_lo};
            o_dec.need_rs1 = 1'b1;
            o_dec.need_rs2 = 1'b1;   // rs2 carries the store data
         end
         rv_core_pkg::OP_BRANCH: begin
            o_dec.imm      = {{19{i_inst.b_fmt.imm_12}}, i_inst.b_fmt.imm_12,
                              i_inst.b_fmt.imm_11, i_inst.b_fmt.imm_10_5,
                              i_inst.b_fmt.imm_4_1, 1'b0};
            o_dec.need_rs1 = 1'b1;
            o_dec.need_rs2 = 1'b1;
            o_dec.use_rs2  = 1'b1;
            case (i_inst.b_fmt.funct3)
               3'h0,
               3'h1:    o_dec.alu_fn = rv_core_pkg::ALU_SUB;   // beq, bne
               3'h4:    o_dec.alu_fn = rv_core_pkg::ALU_SLT;   // blt
               default: o_dec.illegal = 1'b1;
            endcase
         end
         rv_core_pkg::OP_JAL: begin
            o_dec.imm = {{11{i_inst.j_fmt.imm_20}}, i_inst.j_fmt.imm_20,
                         i_inst.j_fmt.imm_19_12, i_inst.j_fmt.imm_11,
                         i_inst.j_fmt.imm_10_1, 1'b0};
         end
         rv_core_pkg::OP_LUI: begin
            o_dec.imm = {i_inst.u_fmt.imm, 12'b0};
         end
         rv_core_pkg::OP_SYSTEM: begin
            // Anything but ebreak faults
            o_dec.illegal = (i_inst.i_fmt.imm != 12'h001) ||
                            (i_inst.i_fmt.funct3 != 3'h0);
         end
         default: o_dec.illegal = 1'b1;
      endcase
   end

endmodule

`default_nettype wire

// ==== design/rv_sequencer.sv ====
// Multicycle control with registers kept in memory; one instruction at a time
// Starts on i_run from RV_RESET_PC and stays halted or faulted until reset

`timescale 1ns/10ps
`default_nettype none

`include "rv_core_cfg.svh"

module rv_sequencer (
   input  wire                        clk,
   input  wire                        i_arst_n,
   input  wire                        i_run,
   output rv_core_pkg::mem_req_s      o_mem,
   input  wire [`RV_XLEN-1:0]         i_rd_data,
   input  wire                        i_rd_valid,
   output rv_core_pkg::inst_u         o_inst,
   input  wire rv_core_pkg::dec_s     i_dec,
   output logic [`RV_XLEN-1:0]        o_alu_a,
   output logic [`RV_XLEN-1:0]        o_alu_b,
   output rv_core_pkg::alu_fn_e       o_alu_fn,
   input  wire [`RV_XLEN-1:0]         i_alu_out,
   input  wire                        i_alu_zero,
   output logic                       o_idle,
   output logic                       o_halted,
   output logic                       o_fault
);

   typedef enum logic [3:0] {
      S_IDLE, S_FETCH, S_LD_INST, S_EXEC, S_LD_RS1, S_LD_RS2,
      S_LD_RD, S_STORE, S_HALT, S_FAULT
   } state_e;

   state_e                 state;
   logic [`RV_AW-1:0]      pc;      // Address of the current instruction
   rv_core_pkg::inst_u     inst_q;
   logic [`RV_XLEN-1:0]    rs1_q;
   logic [`RV_XLEN-1:0]    rs2_q;
   logic                   rs1_vld;
   logic                   rs2_vld;
   logic                   taken;
   logic                   wb_on;
   logic [`RV_AW-1:0]      next_pc;
   logic [`RV_AW-1:0]      link;
   logic [`RV_XLEN-1:0]    wb_val;

   function automatic logic [`RV_AW-1:0] reg_addr(input logic [4:0] r);
      reg_addr = {{(`RV_AW-7){1'b0}}, r, 2'b00};
   endfunction

   assign o_inst   = inst_q;
   assign o_alu_a  = rs1_q;
   assign o_alu_b  = i_dec.use_rs2 ? rs2_q : i_dec.imm;
   assign o_alu_fn = i_dec.alu_fn;

   assign o_idle   = (state == S_IDLE) || (state == S_HALT) || (state == S_FAULT);
   assign o_halted = (state == S_HALT);
   assign o_fault  = (state == S_FAULT);

   assign link  = pc + `RV_AW'd4;
   assign wb_on = (i_dec.rd != 5'd0);   // x0 writes dropped

   always_comb begin
      case (i_dec.funct3)
         3'h0:    taken = i_alu_zero;
         3'h1:    taken = !i_alu_zero;
         3'h4:    taken = i_alu_out[0];
         default: taken = 1'b0;
      endcase
   end

   always_comb begin
      next_pc = link;
      wb_val  = i_alu_out;
      case (i_dec.opcode)
         rv_core_pkg::OP_BRANCH: if (taken) next_pc = pc + i_dec.imm[`RV_AW-1:0];
         rv_core_pkg::OP_JAL: begin
            next_pc = pc + i_dec.imm[`RV_AW-1:0];
            wb_val  = {{(`RV_XLEN-`RV_AW){1'b0}}, link};
         end
         rv_core_pkg::OP_JALR: begin
            next_pc = {i_alu_out[`RV_AW-1:1], 1'b0};
            wb_val  = {{(`RV_XLEN-`RV_AW){1'b0}}, link};
         end
         rv_core_pkg::OP_LUI: wb_val = i_dec.imm;
         default: ;
      endcase
   end

   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         state   <= S_IDLE;
         pc      <= `RV_RESET_PC;
         o_mem   <= '0;
         rs1_vld <= 1'b0;
         rs2_vld <= 1'b0;
      end else begin
         case (state)
            S_IDLE: if (i_run) state <= S_FETCH;

            S_FETCH: begin
               rs1_vld     <= 1'b0;
               rs2_vld     <= 1'b0;
               o_mem.addr  <= pc;
               o_mem.rd_en <= 1'b1;
               state       <= S_LD_INST;
            end

            S_LD_INST: if (i_rd_valid) begin
               o_mem.rd_en <= 1'b0;
               inst_q      <= i_rd_data;
               state       <= S_EXEC;
            end

            S_EXEC: begin
               if (i_dec.illegal) begin
                  state <= S_FAULT;
               end else if (i_dec.need_rs1 && !rs1_vld) begin
                  if (i_dec.rs1 == 5'd0) begin
                     rs1_q   <= '0;   // x0 needs no memory read
                     rs1_vld <= 1'b1;
                  end else begin
                     o_mem.addr  <= reg_addr(i_dec.rs1);
                     o_mem.rd_en <= 1'b1;
                     state       <= S_LD_RS1;
                  end
               end else if (i_dec.need_rs2 && !rs2_vld) begin
                  if (i_dec.rs2 == 5'd0) begin
                     rs2_q   <= '0;
                     rs2_vld <= 1'b1;
                  end else begin
                     o_mem.addr  <= reg_addr(i_dec.rs2);
                     o_mem.rd_en <= 1'b1;
                     state       <= S_LD_RS2;
                  end
               end else begin
                  case (i_dec.opcode)
                     rv_core_pkg::OP_R_ALU, rv_core_pkg::OP_I_ALU, rv_core_pkg::OP_LUI,
                     rv_core_pkg::OP_JAL, rv_core_pkg::OP_JALR: begin
                        pc          <= next_pc;
                        o_mem.addr  <= reg_addr(i_dec.rd);
                        o_mem.wdata <= wb_val;
                        o_mem.wr_en <= wb_on;
                        state       <= wb_on ? S_STORE : S_FETCH;
                     end
                     rv_core_pkg::OP_LOAD: begin
                        pc          <= next_pc;
                        o_mem.addr  <= i_alu_out[`RV_AW-1:0];
                        o_mem.rd_en <= 1'b1;
                        state       <= S_LD_RD;
                     end
                     rv_core_pkg::OP_STORE: begin
                        pc          <= next_pc;
                        o_mem.addr  <= i_alu_out[`RV_AW-1:0];
                        o_mem.wdata <= rs2_q;
                        o_mem.wr_en <= 1'b1;
                        state       <= S_STORE;
                     end
                     rv_core_pkg::OP_BRANCH: begin
                        pc    <= next_pc;
                        state <= S_FETCH;
                     end
                     rv_core_pkg::OP_SYSTEM: state <= S_HALT;   // ebreak
                     default:                state <= S_FAULT;
                  endcase
               end
            end

            S_LD_RS1: if (i_rd_valid) begin
               o_mem.rd_en <= 1'b0;
               rs1_q       <= i_rd_data;
               rs1_vld     <= 1'b1;
               state       <= S_EXEC;
            end

            S_LD_RS2: if (i_rd_valid) begin
               o_mem.rd_en <= 1'b0;
               rs2_q       <= i_rd_data;
               rs2_vld     <= 1'b1;
               state       <= S_EXEC;
            end

            S_LD_RD: if (i_rd_valid) begin
               o_mem.rd_en <= 1'b0;
               o_mem.addr  <= reg_addr(i_dec.rd);
               o_mem.wdata <= i_rd_data;
               o_mem.wr_en <= wb_on;
               state       <= wb_on ? S_STORE : S_FETCH;
            end

            S_STORE: begin
               o_mem.wr_en <= 1'b0;
               state       <= S_FETCH;
            end

            S_HALT, S_FAULT: ;

            default: state <= S_FAULT;
         endcase
      end
   end

   // One access at a time on the memory port
   a_rd_wr_excl: assert property (@(posedge clk) disable iff (!i_arst_n)
      !(o_mem.rd_en && o_mem.wr_en));

   a_wr_strobe: assert property (@(posedge clk) disable iff (!i_arst_n)
      o_mem.wr_en |=> !o_mem.wr_en);

endmodule

`default_nettype wire

// ==== design/rv_mem.sv ====
// Word RAM shared by core and host; byte address bits [1:0] are ignored
// Host access is honoured only while the core reports idle

`timescale 1ns/10ps
`default_nettype none

`include "rv_core_cfg.svh"

module rv_mem (
   input  wire                          clk,
   input  wire                          i_arst_n,
   input  wire rv_core_pkg::mem_req_s   i_core,
   output logic [`RV_XLEN-1:0]          o_rd_data,
   output logic                         o_rd_valid,
   input  wire                          i_core_idle,
   input  wire rv_core_pkg::host_req_s  i_host,
   output logic [`RV_XLEN-1:0]          o_host_rdata
);

   localparam int IW = $clog2(`RV_MEM_WORDS);
   localparam int CW = $clog2(`RV_MEM_RD_LAT + 1);

   logic [`RV_XLEN-1:0] mem [`RV_MEM_WORDS];
   logic [CW-1:0]       lat_cnt;
   logic [IW-1:0]       core_idx;
   logic [IW-1:0]       host_idx;
   logic                rd_fire;
   logic                host_wr;
   logic                host_rd;

   assign core_idx = i_core.addr[IW+1:2];
   assign host_idx = i_host.addr[IW+1:2];
   assign host_wr  = i_host.valid && i_host.write && i_core_idle;
   assign host_rd  = i_host.valid && !i_host.write && i_core_idle;

   // Last latency cycle of a pending read
   assign rd_fire  = i_core.rd_en && !o_rd_valid && (lat_cnt == CW'(`RV_MEM_RD_LAT - 1));

   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         lat_cnt    <= '0;
         o_rd_valid <= 1'b0;
      end else if (o_rd_valid) begin
         lat_cnt    <= '0;   // Single-cycle pulse while rd_en drops
         o_rd_valid <= 1'b0;
      end else if (rd_fire) begin
         lat_cnt    <= '0;
         o_rd_valid <= 1'b1;
      end else if (i_core.rd_en) begin
         lat_cnt    <= lat_cnt + 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (i_core.wr_en)
         mem[core_idx] <= i_core.wdata;
      else if (host_wr)
         mem[host_idx] <= i_host.data;
      if (rd_fire)
         o_rd_data <= mem[core_idx];
      if (host_rd)
         o_host_rdata <= mem[host_idx];
   end

   a_idle_no_core: assert property (@(posedge clk) disable iff (!i_arst_n)
      i_core_idle |-> !(i_core.rd_en || i_core.wr_en));

   a_core_in_range: assert property (@(posedge clk) disable iff (!i_arst_n)
      (i_core.rd_en || i_core.wr_en) |-> (i_core.addr[`RV_AW-1:2] < `RV_MEM_WORDS));

endmodule

`default_nettype wire

// ==== design/rv_top.sv ====
// RV32I subset core with its shared register/program/data memory
// Host port works only while the core is idle, halted or faulted

`timescale 1ns/10ps
`default_nettype none

`include "rv_core_cfg.svh"

module rv_top (
   input  wire                          clk,
   input  wire                          i_arst_n,
   input  wire                          i_run,
   input  wire rv_core_pkg::host_req_s  i_host,
   output logic [`RV_XLEN-1:0]          o_host_rdata,
   output logic                         o_halted,
   output logic                         o_fault
);

   rv_core_pkg::mem_req_s  core_req;
   rv_core_pkg::inst_u     inst;
   rv_core_pkg::dec_s      dec;
   rv_core_pkg::alu_fn_e   alu_fn;
   logic [`RV_XLEN-1:0]    rd_data;
   logic                   rd_valid;
   logic [`RV_XLEN-1:0]    alu_a;
   logic [`RV_XLEN-1:0]    alu_b;
   logic [`RV_XLEN-1:0]    alu_out;
   logic                   alu_zero;
   logic                   core_idle;

   rv_sequencer seq_i (
      .clk        (clk),
      .i_arst_n   (i_arst_n),
      .i_run      (i_run),
      .o_mem      (core_req),
      .i_rd_data  (rd_data),
      .i_rd_valid (rd_valid),
      .o_inst     (inst),
      .i_dec      (dec),
      .o_alu_a    (alu_a),
      .o_alu_b    (alu_b),
      .o_alu_fn   (alu_fn),
      .i_alu_out  (alu_out),
      .i_alu_zero (alu_zero),
      .o_idle     (core_idle),
      .o_halted   (o_halted),
      .o_fault    (o_fault)
   );

   rv_decoder dec_i (
      .i_inst (inst),
      .o_dec  (dec)
   );

   rv_alu alu_i (
      .i_a    (alu_a),
      .i_b    (alu_b),
      .i_fn   (alu_fn),
      .o_out  (alu_out),
      .o_zero (alu_zero)
   );

   rv_mem mem_i (
      .clk          (clk),
      .i_arst_n     (i_arst_n),
      .i_core       (core_req),
      .o_rd_data    (rd_data),
      .o_rd_valid   (rd_valid),
      .i_core_idle  (core_idle),
      .i_host       (i_host),
      .o_host_rdata (o_host_rdata)
   );

endmodule

`default_nettype wire

// ==== bench/tb_rv_cases.svh ====
// Test programs and the words expected after each run
// Up to 12 words per program at RV_RESET_PC and up to 4 checked words

`ifndef TB_RV_CASES_SVH
`define TB_RV_CASES_SVH

localparam int          NUM_CASES = 8;
localparam int          PROG_BASE = `RV_RESET_PC;
localparam logic [31:0] EBREAK    = 32'h0010_0073;

typedef struct packed {
   logic [11:0][31:0] prog;
   logic [3:0][15:0]  chk_addr;
   logic [3:0][31:0]  chk_val;
   logic [2:0]        n_chk;
   logic              fault;   // Run must end in o_fault
} case_s;

case_s cases [NUM_CASES];
string case_name [NUM_CASES];
int    fill_case;
int    fill_pos;

// RV32I encodings
function automatic logic [31:0] rtype(input int f7, f3, rd, rs1, rs2);
   rtype = {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'h33};
endfunction

function automatic logic [31:0] itype(input int op, f3, rd, rs1, imm);
   itype = {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op[6:0]};
endfunction

function automatic logic [31:0] stype(input int rs2, rs1, imm);
   stype = {imm[11:5], rs2[4:0], rs1[4:0], 3'h2, imm[4:0], 7'h23};   // sw
endfunction

function automatic logic [31:0] btype(input int f3, rs1, rs2, off);
   btype = {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11], 7'h63};
endfunction

function automatic logic [31:0] utype(input int rd, imm);
   utype = {imm[19:0], rd[4:0], 7'h37};   // lui
endfunction

function automatic logic [31:0] jtype(input int rd, off);
   jtype = {off[20], off[10:1], off[11], off[19:12], rd[4:0], 7'h6f};
endfunction

function automatic logic [31:0] addi(input int rd, rs1, imm);
   addi = itype('h13, 0, rd, rs1, imm);
endfunction

function automatic logic [15:0] xreg(input int n);
   xreg = 16'(n * 4);
endfunction

task automatic begin_case(input int c, input string name, input logic fault);
   fill_case       = c;
   fill_pos        = 0;
   cases[c]        = '0;
   cases[c].fault  = fault;
   case_name[c]    = name;
endtask

task automatic emit(input logic [31:0] w);
   cases[fill_case].prog[fill_pos[3:0]] = w;
   fill_pos++;
endtask

task automatic expect_word(input logic [15:0] addr, input logic [31:0] val);
   logic [1:0] k;
   k = cases[fill_case].n_chk[1:0];
   cases[fill_case].chk_addr[k] = addr;
   cases[fill_case].chk_val[k]  = val;
   cases[fill_case].n_chk++;
endtask

task automatic setup_cases();
   logic [31:0] ra;
   logic [31:0] rb;
   logic [31:0] va;
   logic [31:0] vb;
   ra = $random(seed);
   rb = $random(seed);
   va = {{20{ra[11]}}, ra[11:0]};   // addi sign-extends
   vb = {{20{rb[11]}}, rb[11:0]};

   begin_case(0, "add sub xor or", 1'b0);
   emit(addi(1, 0, ra));
   emit(addi(2, 0, rb));
   emit(rtype(0, 0, 3, 1, 2));
   emit(rtype('h20, 0, 4, 1, 2));
   emit(rtype(0, 4, 5, 1, 2));
   emit(rtype(0, 6, 6, 1, 2));
   emit(EBREAK);
   expect_word(xreg(3), va + vb);
   expect_word(xreg(4), va - vb);
   expect_word(xreg(5), va ^ vb);
   expect_word(xreg(6), va | vb);

   begin_case(1, "and sll srl slt", 1'b0);
   emit(addi(1, 0, ra));
   emit(addi(2, 0, rb));
   emit(rtype(0, 7, 3, 1, 2));
   emit(rtype(0, 1, 4, 1, 2));
   emit(rtype(0, 5, 5, 1, 2));
   emit(rtype(0, 2, 6, 1, 2));
   emit(EBREAK);
   expect_word(xreg(3), va & vb);
   expect_word(xreg(4), va << vb[4:0]);
   expect_word(xreg(5), va >> vb[4:0]);
   expect_word(xreg(6), (va < vb) ? 32'd1 : 32'd0);   // slt compares unsigned

   begin_case(2, "lui and immediates", 1'b0);
   emit(utype(1, 'h12345));
   emit(addi(2, 0, -5));
   emit(addi(3, 0, -1));
   emit(utype(3, 'habcde));   // Low 12 bits of x3 must clear
   emit(addi(4, 3, -2048));
   emit(EBREAK);
   expect_word(xreg(1), 32'h1234_5000);
   expect_word(xreg(2), 32'hffff_fffb);
   expect_word(xreg(3), 32'habcd_e000);
   expect_word(xreg(4), 32'habcd_d800);

   begin_case(3, "sw lw and x0", 1'b0);
   emit(addi(1, 0, 'h200));
   emit(utype(2, 'h89abc));
   emit(addi(2, 2, 'h5ef));
   emit(stype(2, 1, 0));
   emit(itype('h03, 2, 3, 1, 0));   // lw x3
   emit(addi(0, 0, 123));
   emit(itype('h03, 2, 0, 1, 0));   // lw x0
   emit(addi(4, 0, 7));
   emit(EBREAK);
   expect_word(16'h0200, 32'h89ab_c5ef);
   expect_word(xreg(3), 32'h89ab_c5ef);
   expect_word(xreg(0), 32'h0);
   expect_word(xreg(4), 32'd7);

   begin_case(4, "beq bne", 1'b0);
   emit(addi(1, 0, 5));
   emit(addi(2, 0, 5));
   emit(addi(3, 0, 9));
   emit(btype(0, 1, 2, 8));   // Taken
   emit(addi(10, 0, 1));
   emit(btype(0, 1, 3, 8));
   emit(addi(11, 0, 1));
   emit(btype(1, 1, 3, 8));   // Taken
   emit(addi(12, 0, 1));
   emit(btype(1, 1, 2, 8));
   emit(addi(13, 0, 1));
   emit(EBREAK);
   expect_word(xreg(10), 32'd0);
   expect_word(xreg(11), 32'd1);
   expect_word(xreg(12), 32'd0);
   expect_word(xreg(13), 32'd1);

   begin_case(5, "blt and loop", 1'b0);
   emit(addi(1, 0, 3));
   emit(addi(2, 0, 7));
   emit(btype(4, 1, 2, 8));   // Taken
   emit(addi(10, 0, 1));
   emit(btype(4, 2, 1, 8));
   emit(addi(11, 0, 1));
   emit(addi(12, 12, 1));
   emit(btype(4, 12, 1, -4));   // Backward until x12 reaches 3
   emit(EBREAK);
   expect_word(xreg(10), 32'd0);
   expect_word(xreg(11), 32'd1);
   expect_word(xreg(12), 32'd3);

   begin_case(6, "jal jalr", 1'b0);
   emit(jtype(1, 8));
   emit(addi(10, 0, 1));
   emit(addi(5, 0, PROG_BASE + 'h1c));
   emit(itype('h67, 0, 2, 5, 4));   // jalr x2, 4(x5)
   for (int i = 0; i < 4; i++)
      emit(addi(10, 0, 1));
   emit(addi(13, 0, 5));   // jalr lands here
   emit(EBREAK);
   expect_word(xreg(1), 32'(PROG_BASE + 4));
   expect_word(xreg(2), 32'(PROG_BASE + 'h10));
   expect_word(xreg(10), 32'd0);
   expect_word(xreg(13), 32'd5);

   begin_case(7, "illegal opcode", 1'b1);
   emit(addi(1, 0, 'h123));
   emit(addi(2, 0, 'h45));
   emit(32'h1234_5097);   // auipc x1
   emit(addi(3, 0, 9));
   emit(EBREAK);
   expect_word(xreg(1), 32'h0000_0123);
   expect_word(xreg(2), 32'h0000_0045);
   expect_word(xreg(3), 32'h0);
endtask

`endif

// ==== bench/tb_rv_top.sv ====
// Runs every table program from a zeroed register file and data area
// Core is reset after each run and results are read through the host port

`timescale 1ns/10ps
`default_nettype none

`include "rv_core_cfg.svh"

module tb_rv_top;

   localparam int RESET_CYCLES = 16;
   localparam int DATA_WORDS   = 4;

   logic                   clk;
   logic                   arst_n;
   logic                   run;
   rv_core_pkg::host_req_s host;
   logic [31:0]            host_rdata;
   logic                   halted;
   logic                   fault;
   integer                 seed;
   int                     cycles = 0;
   int                     errors;
   int                     checks;

   `include "tb_rv_cases.svh"

   // Each program gets 12 instructions of 20 cycles
   localparam int CYCLE_LIMIT = NUM_CASES * 12 * 20 + 500;

   rv_top dut_i (
      .clk          (clk),
      .i_arst_n     (arst_n),
      .i_run        (run),
      .i_host       (host),
      .o_host_rdata (host_rdata),
      .o_halted     (halted),
      .o_fault      (fault)
   );

   always #5 clk = ~clk;

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= CYCLE_LIMIT) begin
         $display("Timeout: the core never halted within %0d cycles", CYCLE_LIMIT);
         $display("CHECKS FAILED");
         $finish;
      end
   end

   task automatic check_word(input logic [31:0] got, input logic [31:0] exp,
                             input string what);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("Mismatch at %0t: %s read %08h, expected %08h", $time, what, got, exp);
      end
   endtask

   task automatic host_write(input logic [15:0] addr, input logic [31:0] data);
      @(negedge clk);
      host.valid = 1'b1;
      host.write = 1'b1;
      host.addr  = addr;
      host.data  = data;
   endtask

   // Data comes back one cycle after the request
   task automatic host_read(input logic [15:0] addr, output logic [31:0] data);
      @(negedge clk);
      host.valid = 1'b1;
      host.write = 1'b0;
      host.addr  = addr;
      @(negedge clk);
      host.valid = 1'b0;
      data       = host_rdata;
   endtask

   task automatic apply_reset(input int n);
      @(negedge clk);
      arst_n = 1'b0;
      run    = 1'b0;
      repeat (n) @(negedge clk);
      arst_n = 1'b1;
   endtask

   task automatic run_case(input int c);
      logic [31:0] got;
      int          errs_before;
      errs_before = errors;
      for (int r = 0; r < 32; r++)
         host_write(xreg(r), 32'h0);
      for (int d = 0; d < DATA_WORDS; d++)
         host_write(16'('h200 + d * 4), 32'h0);
      for (int w = 0; w < 12; w++)
         host_write(16'(PROG_BASE + w * 4), cases[c].prog[w[3:0]]);
      @(negedge clk);
      host.valid = 1'b0;
      run        = 1'b1;
      while (!(halted || fault))
         @(negedge clk);
      if (fault && !cases[c].fault) begin
         errors++;
         $display("Test %0d ended in a fault although it should halt", c);
      end else if (halted && cases[c].fault) begin
         errors++;
         $display("Test %0d halted although its opcode should fault", c);
      end
      apply_reset(2);
      for (int k = 0; k < cases[c].n_chk; k++) begin
         host_read(cases[c].chk_addr[k[1:0]], got);
         check_word(got, cases[c].chk_val[k[1:0]],
                    $sformatf("test %0d word %04h", c, cases[c].chk_addr[k[1:0]]));
      end
      $display("Test %0d %s: %s", c, case_name[c], (errors == errs_before) ? "pass" : "fail");
   endtask

   initial begin
      clk    = 1'b0;
      arst_n = 1'b0;
      run    = 1'b0;
      host   = '0;
      seed   = 39;
      errors = 0;
      checks = 0;
      setup_cases();
      repeat (RESET_CYCLES) @(negedge clk);
      arst_n = 1'b1;
      for (int c = 0; c < NUM_CASES; c++)
         run_case(c);
      $display("%0d tests, %0d checks, %0d errors", NUM_CASES, checks, errors);
      if (errors == 0)
         $display("ALL CHECKS PASSED");
      else
         $display("CHECKS FAILED");
      $finish;
   end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+design
+incdir+bench
design/rv_core_pkg.sv
design/rv_alu.sv
design/rv_decoder.sv
design/rv_sequencer.sv
design/rv_mem.sv
design/rv_top.sv
bench/tb_rv_top.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds tb_rv_top with Verilator, runs it and searches the log for the pass message
cd "$(dirname "$0")" || exit 1
rm -f sim.log \
   && verilator --binary --timing --assert -Wno-fatal --top-module tb_rv_top \
      -f build.f -o tb_rv_top \
   && ./obj_dir/tb_rv_top | tee sim.log \
   && grep -q "ALL CHECKS PASSED" sim.log \
   && echo "Simulation passed" \
   || { echo "Simulation failed"; exit 1; }
